//--- Bender.yml
package:
  name: cmo_handler

sources:
  - include_dirs:
      - logic
    files:
      - logic/cmo_pkg.sv
      - logic/cmo_walk_counter.sv
      - logic/cmo_flush_fifo.sv
      - logic/cmo_fsm.sv
      - logic/cmo_handler.sv
  - target: test
    files:
      - verification/cmo_handler_assert.sv
      - verification/cmo_handler_tb.sv

//--- list.f
+incdir+logic
logic/cmo_pkg.sv
logic/cmo_walk_counter.sv
logic/cmo_flush_fifo.sv
logic/cmo_fsm.sv
logic/cmo_handler.sv
verification/cmo_handler_assert.sv
verification/cmo_handler_tb.sv

//--- logic/cmo_flush_fifo.sv
/*
 * Registered FIFO, an entry is visible at the output one cycle after push.
 * A push while full is dropped, the writer checks not_full_o first.
 */
`timescale 1ns/1ns
`default_nettype none

`include "cmo_macros.svh"

module cmo_flush_fifo #(
    parameter int DEPTH = `CMO_FLUSH_DEPTH
) (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,
    input  wire logic              push_i,
    input  cmo_pkg::cmo_nline_t    nline_i,
    input  cmo_pkg::cmo_way_vec_t  way_i,
    output logic                   not_full_o,
    output logic                   empty_o,
    output logic                   alloc_o,
    input  wire logic              alloc_ready_i,
    output cmo_pkg::cmo_nline_t    alloc_nline_o,
    output cmo_pkg::cmo_way_vec_t  alloc_way_o
);
    import cmo_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    cmo_nline_t   nline_mem [DEPTH];
    cmo_way_vec_t way_mem   [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic do_push, do_pop;

    assign empty_o    = (count_q == '0);
    assign not_full_o = (count_q != CNT_W'(DEPTH));
    assign alloc_o    = ~empty_o;
    assign do_push    = push_i & not_full_o;
    assign do_pop     = alloc_o & alloc_ready_i;

    assign alloc_nline_o = nline_mem[rd_ptr_q];
    assign alloc_way_o   = way_mem[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            nline_mem[wr_ptr_q] <= nline_i;
            way_mem[wr_ptr_q]   <= way_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/cmo_fsm.sv
/*
 * One operation at a time. A flush walk takes two cycles per entry and
 * stalls while the FIFO is full. A pending response blocks new requests.
 */
`timescale 1ns/1ns
`default_nettype none

module cmo_fsm (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  req_valid_i,
    input  cmo_pkg::cmo_op_e           req_op_i,
    input  cmo_pkg::cmo_tid_t          req_tid_i,
    input  wire logic                  req_need_rsp_i,
    output logic                       req_ready_o,
    output logic                       req_wait_o,
    input  wire logic                  core_rsp_ready_i,
    output logic                       core_rsp_valid_o,
    output cmo_pkg::cmo_tid_t          core_rsp_tid_o,
    input  wire logic                  wbuf_empty_i,
    input  wire logic                  mshr_empty_i,
    input  wire logic                  flush_empty_i,
    output logic                       wbuf_flush_all_o,
    output logic                       dir_check_o,
    output cmo_pkg::cmo_set_t          dir_check_set_o,
    output cmo_pkg::cmo_way_vec_t      dir_check_way_o,
    input  wire logic                  dir_entry_valid_i,
    input  wire logic                  dir_entry_dirty_i,
    input  cmo_pkg::cmo_tag_t          dir_entry_tag_i,
    output logic                       dir_updt_o,
    output cmo_pkg::cmo_set_t          dir_updt_set_o,
    output cmo_pkg::cmo_way_vec_t      dir_updt_way_o,
    output logic                       dir_updt_valid_o,
    output logic                       dir_updt_dirty_o,
    output cmo_pkg::cmo_tag_t          dir_updt_tag_o,
    input  cmo_pkg::cmo_set_t          set_i,
    input  cmo_pkg::cmo_way_vec_t      way_i,
    input  wire logic                  set_last_i,
    input  wire logic                  way_last_i,
    output logic                       walk_clear_o,
    output logic                       walk_step_o,
    input  wire logic                  fifo_not_full_i,
    input  wire logic                  fifo_empty_i,
    output logic                       fifo_push_o,
    output cmo_pkg::cmo_nline_t        fifo_nline_o,
    output cmo_pkg::cmo_way_vec_t      fifo_way_o
);
    import cmo_pkg::*;

    cmo_state_e   state_q, state_d;
    cmo_op_e      op_q;
    cmo_tid_t     tid_q;
    logic         need_q;
    logic         rsp_valid_q;
    logic         req_accept;
    logic         op_done;
    logic         inval_op;

    // Check issued last cycle, its result is on the entry inputs now
    logic         chk_q;
    logic         chk_issue;
    cmo_set_t     chk_set_q;
    cmo_way_vec_t chk_way_q;

    assign req_ready_o = (state_q == CMOH_IDLE) & (~rsp_valid_q | core_rsp_ready_i);
    assign req_accept  = req_valid_i & req_ready_o;
    assign req_wait_o  = (state_q == CMOH_FENCE_WAIT) | (state_q == CMOH_WAIT_MSHR);
    assign inval_op    = (op_q == CMO_FLUSH_INVAL_ALL);

    assign core_rsp_valid_o = rsp_valid_q;
    assign core_rsp_tid_o   = tid_q;

    assign dir_check_o     = chk_issue;
    assign dir_check_set_o = set_i;
    assign dir_check_way_o = way_i;

    assign fifo_nline_o = {dir_entry_tag_i, chk_set_q};
    assign fifo_way_o   = chk_way_q;

    always_comb begin
        state_d          = state_q;
        op_done          = 1'b0;
        chk_issue        = 1'b0;
        walk_clear_o     = 1'b0;
        walk_step_o      = 1'b0;
        wbuf_flush_all_o = 1'b0;
        fifo_push_o      = 1'b0;
        dir_updt_o       = 1'b0;
        dir_updt_set_o   = '0;
        dir_updt_way_o   = '0;
        dir_updt_valid_o = 1'b0;
        dir_updt_dirty_o = 1'b0;
        dir_updt_tag_o   = '0;

        case (state_q)
            CMOH_IDLE: begin
                if (req_accept) begin
                    if (req_op_i == CMO_FENCE) begin
                        wbuf_flush_all_o = 1'b1;
                        if (wbuf_empty_i) begin
                            op_done = 1'b1;
                        end else begin
                            state_d = CMOH_FENCE_WAIT;
                        end
                    end else begin
                        state_d = CMOH_WAIT_MSHR;
                    end
                end
            end
            CMOH_FENCE_WAIT: begin
                wbuf_flush_all_o = 1'b1;
                if (wbuf_empty_i) begin
                    op_done = 1'b1;
                    state_d = CMOH_IDLE;
                end
            end
            CMOH_WAIT_MSHR: begin
                if (mshr_empty_i) begin
                    walk_clear_o = 1'b1;
                    state_d = (op_q == CMO_INVAL_ALL) ? CMOH_INVAL_SET : CMOH_FLUSH_NEXT;
                end
            end
            CMOH_INVAL_SET: begin
                // All ways of one set per cycle, step plus clear moves to the next set
                dir_updt_o     = 1'b1;
                dir_updt_set_o = set_i;
                dir_updt_way_o = '1;
                walk_step_o    = 1'b1;
                walk_clear_o   = 1'b1;
                if (set_last_i) begin
                    op_done = 1'b1;
                    state_d = CMOH_IDLE;
                end
            end
            CMOH_FLUSH_NEXT: begin
                if (!chk_q && fifo_not_full_i) begin
                    chk_issue   = 1'b1;
                    walk_step_o = 1'b1;
                    if (set_last_i && way_last_i) begin
                        state_d = CMOH_FLUSH_LAST;
                    end
                end
            end
            CMOH_FLUSH_LAST: begin
                // Last entry handled and every write-back gone
                if (!chk_q && fifo_empty_i && flush_empty_i) begin
                    op_done = 1'b1;
                    state_d = CMOH_IDLE;
                end
            end
            default: begin
                state_d = CMOH_IDLE;
            end
        endcase

        // Result of the previous check, clean or drop the entry
        if (chk_q) begin
            dir_updt_o       = dir_entry_valid_i & (dir_entry_dirty_i | inval_op);
            dir_updt_set_o   = chk_set_q;
            dir_updt_way_o   = chk_way_q;
            dir_updt_valid_o = ~inval_op;
            dir_updt_tag_o   = dir_entry_tag_i;
            fifo_push_o      = dir_entry_valid_i & dir_entry_dirty_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= CMOH_IDLE;
            chk_q       <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            chk_q   <= chk_issue;
            if (op_done) begin
                // An immediate fence ends in IDLE before need_q is loaded
                rsp_valid_q <= (state_q == CMOH_IDLE) ? req_need_rsp_i : need_q;
            end else if (core_rsp_ready_i) begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_accept) begin
            op_q   <= req_op_i;
            tid_q  <= req_tid_i;
            need_q <= req_need_rsp_i;
        end
        if (chk_issue) begin
            chk_set_q <= set_i;
            chk_way_q <= way_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/cmo_handler.sv
/*
 * CMO handler for an 8-set, 2-way write-back cache directory.
 * Directory check data must arrive one cycle after dir_check_o.
 */
`timescale 1ns/1ns
`default_nettype none

module cmo_handler (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,
    input  wire logic              req_valid_i,
    output logic                   req_ready_o,
    input  cmo_pkg::cmo_op_e       req_op_i,
    input  cmo_pkg::cmo_tid_t      req_tid_i,
    input  wire logic              req_need_rsp_i,
    output logic                   req_wait_o,
    input  wire logic              core_rsp_ready_i,
    output logic                   core_rsp_valid_o,
    output cmo_pkg::cmo_tid_t      core_rsp_tid_o,
    output logic                   wbuf_flush_all_o,
    input  wire logic              wbuf_empty_i,
    input  wire logic              mshr_empty_i,
    output logic                   dir_check_o,
    output cmo_pkg::cmo_set_t      dir_check_set_o,
    output cmo_pkg::cmo_way_vec_t  dir_check_way_o,
    input  wire logic              dir_entry_valid_i,
    input  wire logic              dir_entry_dirty_i,
    input  cmo_pkg::cmo_tag_t      dir_entry_tag_i,
    output logic                   dir_updt_o,
    output cmo_pkg::cmo_set_t      dir_updt_set_o,
    output cmo_pkg::cmo_way_vec_t  dir_updt_way_o,
    output logic                   dir_updt_valid_o,
    output logic                   dir_updt_dirty_o,
    output cmo_pkg::cmo_tag_t      dir_updt_tag_o,
    input  wire logic              flush_empty_i,
    output logic                   flush_alloc_o,
    input  wire logic              flush_alloc_ready_i,
    output cmo_pkg::cmo_nline_t    flush_alloc_nline_o,
    output cmo_pkg::cmo_way_vec_t  flush_alloc_way_o
);
    import cmo_pkg::*;

    logic         walk_clear, walk_step;
    cmo_set_t     set_q;
    cmo_way_vec_t way_q;
    logic         way_last, set_last;
    logic         fifo_push, fifo_not_full, fifo_empty;
    cmo_nline_t   fifo_nline;
    cmo_way_vec_t fifo_way;

    cmo_fsm u_fsm (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .req_valid_i      (req_valid_i),
        .req_op_i         (req_op_i),
        .req_tid_i        (req_tid_i),
        .req_need_rsp_i   (req_need_rsp_i),
        .req_ready_o      (req_ready_o),
        .req_wait_o       (req_wait_o),
        .core_rsp_ready_i (core_rsp_ready_i),
        .core_rsp_valid_o (core_rsp_valid_o),
        .core_rsp_tid_o   (core_rsp_tid_o),
        .wbuf_empty_i     (wbuf_empty_i),
        .mshr_empty_i     (mshr_empty_i),
        .flush_empty_i    (flush_empty_i),
        .wbuf_flush_all_o (wbuf_flush_all_o),
        .dir_check_o      (dir_check_o),
        .dir_check_set_o  (dir_check_set_o),
        .dir_check_way_o  (dir_check_way_o),
        .dir_entry_valid_i(dir_entry_valid_i),
        .dir_entry_dirty_i(dir_entry_dirty_i),
        .dir_entry_tag_i  (dir_entry_tag_i),
        .dir_updt_o       (dir_updt_o),
        .dir_updt_set_o   (dir_updt_set_o),
        .dir_updt_way_o   (dir_updt_way_o),
        .dir_updt_valid_o (dir_updt_valid_o),
        .dir_updt_dirty_o (dir_updt_dirty_o),
        .dir_updt_tag_o   (dir_updt_tag_o),
        .set_i            (set_q),
        .way_i            (way_q),
        .set_last_i       (set_last),
        .way_last_i       (way_last),
        .walk_clear_o     (walk_clear),
        .walk_step_o      (walk_step),
        .fifo_not_full_i  (fifo_not_full),
        .fifo_empty_i     (fifo_empty),
        .fifo_push_o      (fifo_push),
        .fifo_nline_o     (fifo_nline),
        .fifo_way_o       (fifo_way)
    );

    cmo_walk_counter u_walk (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .clear_i    (walk_clear),
        .step_i     (walk_step),
        .set_o      (set_q),
        .way_o      (way_q),
        .set_last_o (set_last),
        .way_last_o (way_last)
    );

    cmo_flush_fifo u_flush_fifo (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .push_i        (fifo_push),
        .nline_i       (fifo_nline),
        .way_i         (fifo_way),
        .not_full_o    (fifo_not_full),
        .empty_o       (fifo_empty),
        .alloc_o       (flush_alloc_o),
        .alloc_ready_i (flush_alloc_ready_i),
        .alloc_nline_o (flush_alloc_nline_o),
        .alloc_way_o   (flush_alloc_way_o)
    );

endmodule

`default_nettype wire

//--- logic/cmo_macros.svh
/*
 * Directory geometry and FIFO depth of the CMO handler.
 * CMO_WAYS must be 2 or more, and CMO_FLUSH_DEPTH must be 2 or more.
 */
`ifndef CMO_MACROS_SVH
`define CMO_MACROS_SVH

// Set index width, 8 sets
`define CMO_SET_W 3
// Ways per set, one-hot encoded
`define CMO_WAYS 2
`define CMO_TAG_W 8
// Core transaction id
`define CMO_TID_W 4
// Write-back request slots ahead of the flush controller
`define CMO_FLUSH_DEPTH 3

`endif

//--- logic/cmo_pkg.sv
/*
 * Types shared by the CMO handler blocks.
 * Widths come from cmo_macros.svh.
 */
`default_nettype none

`include "cmo_macros.svh"

package cmo_pkg;

    typedef logic [`CMO_SET_W-1:0]            cmo_set_t;
    typedef logic [`CMO_WAYS-1:0]             cmo_way_vec_t;
    typedef logic [`CMO_TAG_W-1:0]            cmo_tag_t;
    // Line number is the tag above the set index
    typedef logic [`CMO_TAG_W+`CMO_SET_W-1:0] cmo_nline_t;
    typedef logic [`CMO_TID_W-1:0]            cmo_tid_t;

    typedef enum logic [1:0] {
        CMO_FENCE,
        CMO_INVAL_ALL,
        CMO_FLUSH_ALL,
        CMO_FLUSH_INVAL_ALL
    } cmo_op_e;

    typedef enum logic [2:0] {
        CMOH_IDLE,
        CMOH_FENCE_WAIT,
        CMOH_WAIT_MSHR,
        CMOH_INVAL_SET,
        CMOH_FLUSH_NEXT,
        CMOH_FLUSH_LAST
    } cmo_state_e;

endpackage

`default_nettype wire

//--- logic/cmo_walk_counter.sv
/*
 * Walks sets in order and ways in one-hot order within each set.
 * Step together with clear skips the rest of the set and returns to the first way.
 */
`timescale 1ns/1ns
`default_nettype none

`include "cmo_macros.svh"

module cmo_walk_counter (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,
    input  wire logic              clear_i,
    input  wire logic              step_i,
    output cmo_pkg::cmo_set_t      set_o,
    output cmo_pkg::cmo_way_vec_t  way_o,
    output logic                   set_last_o,
    output logic                   way_last_o
);
    import cmo_pkg::*;

    cmo_set_t     set_q;
    cmo_way_vec_t way_q;
    logic         way_wrap;

    assign way_last_o = way_q[`CMO_WAYS-1];
    assign set_last_o = &set_q;
    assign way_wrap   = step_i & (way_last_o | clear_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            set_q <= '0;
            way_q <= cmo_way_vec_t'(1);
        end else begin
            // Set index rolls over to 0 after the last set
            if (way_wrap) begin
                set_q <= set_q + 1'b1;
            end else if (clear_i) begin
                set_q <= '0;
            end
            if (clear_i || way_wrap) begin
                way_q <= cmo_way_vec_t'(1);
            end else if (step_i) begin
                way_q <= {way_q[`CMO_WAYS-2:0], 1'b0};
            end
        end
    end

    assign set_o = set_q;
    assign way_o = way_q;

endmodule

`default_nettype wire

//--- verification/cmo_handler_assert.sv
/*
 * Protocol checks on the CMO handler ports, bound into every instance.
 * fail_count counts assertion failures for the testbench summary.
 */
`timescale 1ns/1ns
`default_nettype none

module cmo_handler_assert (
    input wire logic                  clk_i,
    input wire logic                  rst_ni,
    input wire logic                  req_ready_o,
    input wire logic                  core_rsp_valid_o,
    input wire logic                  core_rsp_ready_i,
    input cmo_pkg::cmo_tid_t          core_rsp_tid_o,
    input wire logic                  dir_check_o,
    input wire logic                  dir_updt_o,
    input wire logic                  flush_alloc_o,
    input wire logic                  flush_alloc_ready_i,
    input cmo_pkg::cmo_nline_t        flush_alloc_nline_o,
    input cmo_pkg::cmo_way_vec_t      flush_alloc_way_o
);
    int unsigned fail_count = 0;

    // Write-back request waits unchanged for the flush controller
    a_flush_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_alloc_o && !flush_alloc_ready_i |=>
            flush_alloc_o && $stable(flush_alloc_nline_o) && $stable(flush_alloc_way_o))
        else begin
            $error("flush request changed before it was accepted");
            fail_count++;
        end

    // Directory traffic only while an operation is in progress
    a_dir_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dir_updt_o || dir_check_o |-> !req_ready_o)
        else begin
            $error("directory access while a new request could be accepted");
            fail_count++;
        end

    a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_rsp_valid_o && !core_rsp_ready_i |=> core_rsp_valid_o && $stable(core_rsp_tid_o))
        else begin
            $error("response dropped or changed before it was taken");
            fail_count++;
        end

endmodule

bind cmo_handler cmo_handler_assert u_assert (.*);

`default_nettype wire

//--- verification/cmo_handler_tb.sv
/*
 * Table-driven testbench for the CMO handler with directory, write-buffer and flush models.
 * Directory contents are reloaded from $random before every walk operation.
 */
`timescale 1ns/1ns
`default_nettype none

module cmo_handler_tb;
    import cmo_pkg::*;

    localparam int N_TESTS     = 8;
    localparam int TEST_CYCLES = 300;
    localparam int TIMEOUT     = N_TESTS * TEST_CYCLES + 600;
    localparam int N_SETS      = 2 ** $bits(cmo_set_t);
    localparam int N_WAYS      = $bits(cmo_way_vec_t);

    typedef logic [$bits(cmo_nline_t)+N_WAYS-1:0] flush_req_t;

    logic clk_i = 1'b0;
    logic rst_ni, req_valid_i, req_ready_o, req_need_rsp_i, req_wait_o;
    logic core_rsp_ready_i, core_rsp_valid_o, wbuf_flush_all_o, wbuf_empty_i, mshr_empty_i;
    logic dir_check_o, dir_entry_valid_i, dir_entry_dirty_i;
    logic dir_updt_o, dir_updt_valid_o, dir_updt_dirty_o;
    logic flush_empty_i, flush_alloc_o, flush_alloc_ready_i;
    cmo_op_e      req_op_i;
    cmo_tid_t     req_tid_i, core_rsp_tid_o;
    cmo_set_t     dir_check_set_o, dir_updt_set_o;
    cmo_way_vec_t dir_check_way_o, dir_updt_way_o, flush_alloc_way_o;
    cmo_tag_t     dir_entry_tag_i, dir_updt_tag_o;
    cmo_nline_t   flush_alloc_nline_o;

    // Test table columns are name, op, tid, need_rsp, drain delay and back-pressure
    string    row_name  [N_TESTS] = '{"fence_now", "fence_wait", "flush_all", "flush_bp",
                                      "flush_inval", "inval_all", "flush_no_rsp", "fence_no_rsp"};
    cmo_op_e  row_op    [N_TESTS] = '{CMO_FENCE, CMO_FENCE, CMO_FLUSH_ALL, CMO_FLUSH_ALL,
                                      CMO_FLUSH_INVAL_ALL, CMO_INVAL_ALL, CMO_FLUSH_ALL, CMO_FENCE};
    cmo_tid_t row_tid   [N_TESTS] = '{4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'h8};
    logic     row_rsp   [N_TESTS] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0};
    int       row_delay [N_TESTS] = '{0, 5, 2, 1, 3, 1, 0, 4};
    logic     row_bp    [N_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0};

    // Directory model and expected copy
    logic     dv [N_SETS][N_WAYS];
    logic     dd [N_SETS][N_WAYS];
    cmo_tag_t dt [N_SETS][N_WAYS];
    logic     ev [N_SETS][N_WAYS];
    logic     ed [N_SETS][N_WAYS];
    cmo_tag_t et [N_SETS][N_WAYS];
    flush_req_t exp_q [$];
    flush_req_t got_q [$];

    integer  seed = 32'h4d212ec4;
    string   cur_name = "reset";
    cmo_op_e cur_op = CMO_FENCE;
    logic    cur_need = 1'b1, bp_on = 1'b0;
    int      err_total = 0, pass_cnt = 0, updt_cnt = 0, exp_updt = 0, drain_cnt = 0;
    int      cycle_cnt = 0;

    // Values seen at the falling edge stay stable until the next rising edge
    logic     acc_seen = 1'b0, rsp_valid_seen = 1'b0, ready_seen = 1'b0, xfer_seen = 1'b0;
    logic     wait_exp = 1'b0, drained = 1'b0;
    cmo_tid_t rsp_tid_seen = '0;
    logic         chk_pend = 1'b0, upd_pend = 1'b0, upd_valid, upd_dirty;
    cmo_set_t     chk_set, upd_set;
    cmo_way_vec_t chk_way, upd_way;
    cmo_tag_t     upd_tag;

    cmo_handler DUT (.*);

    always #4 clk_i = ~clk_i;

    task automatic report_failure(input string msg);
        $display("test %s: %s", cur_name, msg);
        err_total++;
    endtask

    task automatic compare_value(input string what, input int exp_val, input int act_val);
        assert (exp_val == act_val) else begin
            $display("MISMATCH %s %s: expected %0h, actual %0h", cur_name, what, exp_val, act_val);
            err_total++;
        end
    endtask

    function automatic int error_count();
        return err_total + int'(DUT.u_assert.fail_count);
    endfunction

    task automatic step_cycle();
        int rnd;
        @(posedge clk_i);
        #1;
        rnd = $random(seed);
        if (drain_cnt > 0) drain_cnt--;
        wbuf_empty_i        = (drain_cnt == 0);
        mshr_empty_i        = (drain_cnt == 0);
        // Controller stays busy for one cycle after taking a request
        flush_empty_i       = !xfer_seen;
        flush_alloc_ready_i = bp_on ? rnd[0] : 1'b1;
    endtask

    task automatic load_directory();
        int rnd;
        for (int s = 0; s < N_SETS; s++) begin
            for (int w = 0; w < N_WAYS; w++) begin
                rnd      = $random(seed);
                dv[s][w] = rnd[0];
                dd[s][w] = rnd[1];
                dt[s][w] = rnd[15:8];
            end
        end
    endtask

    task automatic build_expected();
        logic inv;
        inv = (cur_op == CMO_FLUSH_INVAL_ALL);
        exp_q.delete();
        exp_updt = (cur_op == CMO_INVAL_ALL) ? N_SETS : 0;
        for (int s = 0; s < N_SETS; s++) begin
            for (int w = 0; w < N_WAYS; w++) begin
                ev[s][w] = dv[s][w];
                ed[s][w] = dd[s][w];
                et[s][w] = dt[s][w];
                if (cur_op == CMO_INVAL_ALL) begin
                    ev[s][w] = 1'b0;
                    ed[s][w] = 1'b0;
                    et[s][w] = '0;
                end else if (cur_op != CMO_FENCE) begin
                    if (ev[s][w] && ed[s][w]) begin
                        exp_q.push_back({et[s][w], cmo_set_t'(s), cmo_way_vec_t'(1 << w)});
                    end
                    if (ev[s][w] && (ed[s][w] || inv)) begin
                        exp_updt++;
                        ed[s][w] = 1'b0;
                        ev[s][w] = ~inv;
                    end
                end
            end
        end
    endtask

    task automatic check_results();
        compare_value("directory updates", exp_updt, updt_cnt);
        compare_value("flush request count", exp_q.size(), got_q.size());
        for (int k = 0; k < exp_q.size() && k < got_q.size(); k++) begin
            compare_value($sformatf("flush request %0d", k), exp_q[k], got_q[k]);
        end
        for (int s = 0; s < N_SETS; s++) begin
            for (int w = 0; w < N_WAYS; w++) begin
                compare_value($sformatf("entry %0d/%0d", s, w), {ev[s][w], ed[s][w], et[s][w]},
                              {dv[s][w], dd[s][w], dt[s][w]});
            end
        end
    endtask

    task automatic run_test(input int i);
        int lat;
        int errs_before;
        errs_before = error_count();
        cur_name = row_name[i];
        cur_op   = row_op[i];
        cur_need = row_rsp[i];
        bp_on    = row_bp[i];
        if (cur_op != CMO_FENCE) load_directory();
        build_expected();
        got_q.delete();
        updt_cnt       = 0;
        drain_cnt      = row_delay[i];
        wbuf_empty_i   = (drain_cnt == 0);
        mshr_empty_i   = (drain_cnt == 0);
        req_valid_i    = 1'b1;
        req_op_i       = row_op[i];
        req_tid_i      = row_tid[i];
        req_need_rsp_i = row_rsp[i];
        step_cycle();
        while (!acc_seen) step_cycle();
        req_valid_i = 1'b0;
        lat = 0;
        if (cur_need) begin
            while (!rsp_valid_seen) begin
                step_cycle();
                lat++;
            end
            compare_value("response tid", row_tid[i], rsp_tid_seen);
            // Fence ends when the drained write buffer is seen, response one cycle later
            if (cur_op == CMO_FENCE) compare_value("fence latency", row_delay[i] + 1, lat);
            // Hold ready low one cycle so the response must wait
            step_cycle();
            core_rsp_ready_i = 1'b1;
            step_cycle();
            core_rsp_ready_i = 1'b0;
        end else begin
            step_cycle();
            while (!ready_seen) step_cycle();
        end
        bp_on = 1'b0;
        repeat (2) step_cycle();
        check_results();
        if (error_count() == errs_before) begin
            $display("test %-13s ok", cur_name);
            pass_cnt++;
        end else begin
            $display("test %-13s failed with %0d errors", cur_name, error_count() - errs_before);
        end
    endtask

    // Falling-edge monitor and capture of directory requests
    always @(negedge clk_i) begin
        if (rst_ni) begin
            acc_seen       = req_valid_i & req_ready_o;
            rsp_valid_seen = core_rsp_valid_o;
            rsp_tid_seen   = core_rsp_tid_o;
            ready_seen     = req_ready_o;
            xfer_seen      = flush_alloc_o & flush_alloc_ready_i;
            if (xfer_seen) got_q.push_back({flush_alloc_nline_o, flush_alloc_way_o});
            chk_pend  = dir_check_o;
            chk_set   = dir_check_set_o;
            chk_way   = dir_check_way_o;
            upd_pend  = dir_updt_o;
            upd_set   = dir_updt_set_o;
            upd_way   = dir_updt_way_o;
            upd_valid = dir_updt_valid_o;
            upd_dirty = dir_updt_dirty_o;
            upd_tag   = dir_updt_tag_o;
            if (dir_updt_o) begin
                updt_cnt++;
                if (cur_op == CMO_INVAL_ALL) begin
                    compare_value("invalidate way mask", (1 << N_WAYS) - 1, dir_updt_way_o);
                    compare_value("invalidate valid bit", 0, dir_updt_valid_o);
                end
            end
            // Wait lasts from acceptance through the cycle the drain is seen
            compare_value("req_wait_o", wait_exp, req_wait_o);
            compare_value("write buffer flush", (cur_op == CMO_FENCE) && (acc_seen || wait_exp),
                          wbuf_flush_all_o);
            drained  = (cur_op == CMO_FENCE) ? wbuf_empty_i : mshr_empty_i;
            wait_exp = (acc_seen && !(cur_op == CMO_FENCE && wbuf_empty_i)) ||
                       (wait_exp && !drained);
            assert (cur_need || !core_rsp_valid_o)
                else report_failure("response raised for a request without need_rsp");
        end
    end

    // Directory read data one cycle after the check and read before the update
    always @(posedge clk_i) begin
        #1;
        if (chk_pend) begin
            for (int w = 0; w < N_WAYS; w++) begin
                if (chk_way[w]) begin
                    dir_entry_valid_i = dv[chk_set][w];
                    dir_entry_dirty_i = dd[chk_set][w];
                    dir_entry_tag_i   = dt[chk_set][w];
                end
            end
        end
        if (upd_pend) begin
            for (int w = 0; w < N_WAYS; w++) begin
                if (upd_way[w]) begin
                    dv[upd_set][w] = upd_valid;
                    dd[upd_set][w] = upd_dirty;
                    dt[upd_set][w] = upd_tag;
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        rst_ni = 1'b0;
        req_valid_i = 1'b0;
        req_op_i = CMO_FENCE;
        req_tid_i = '0;
        req_need_rsp_i = 1'b0;
        core_rsp_ready_i = 1'b0;
        wbuf_empty_i = 1'b1;
        mshr_empty_i = 1'b1;
        flush_empty_i = 1'b1;
        flush_alloc_ready_i = 1'b1;
        dir_entry_valid_i = 1'b0;
        dir_entry_dirty_i = 1'b0;
        dir_entry_tag_i = '0;
        load_directory();
        repeat (4) @(posedge clk_i);
        #1 rst_ni = 1'b1;
        assert (!req_wait_o && !core_rsp_valid_o && !flush_alloc_o && !dir_check_o &&
                !dir_updt_o && !wbuf_flush_all_o)
            else report_failure("outputs not idle after reset");
        for (int i = 0; i < N_TESTS; i++) begin
            run_test(i);
        end
        $display("%0d tests, %0d passed, %0d check errors, %0d assertion failures",
                 N_TESTS, pass_cnt, err_total, DUT.u_assert.fail_count);
        if (error_count() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
